//--- design/exu_collect.sv
`timescale 1ns/100ps
`include "exu_config.svh"

module exu_collect (
  input  logic                      clk,
  input  logic                      rst_n_i,
  input  logic [`EXU_NUM_LANES-1:0] lane_valid_i,
  input  exu_pkg::exu_res_t         lane_res_i [`EXU_NUM_LANES],
  output logic [`EXU_NUM_LANES-1:0] lane_pop_o,
  output logic                      out_req_o,
  output exu_pkg::exu_res_t         out_res_o,
  input  logic                      out_ack_i
);

  localparam int NUM_LANES = `EXU_NUM_LANES;
  localparam int PTR_W = $clog2(NUM_LANES);

  typedef enum logic [1:0] {
    COL_IDLE         = 2'd0,
    COL_REQ_HIGH     = 2'd1,
    COL_WAIT_ACK_LOW = 2'd2
  } col_state_e;

  col_state_e              state_q;
  logic [PTR_W-1:0]        ptr_q;
  logic [NUM_LANES-1:0]    pop_q;
  logic                    offer;
  exu_pkg::exu_res_t       res_q;

  // previous ack must be gone before the next offer
  assign offer = (state_q == COL_IDLE) && lane_valid_i[ptr_q] && !out_ack_i;

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      state_q <= COL_IDLE;
      ptr_q   <= '0;
      pop_q   <= '0;
    end else begin
      pop_q <= '0;
      case (state_q)
        COL_IDLE: if (offer) state_q <= COL_REQ_HIGH;
        COL_REQ_HIGH: begin
          if (out_ack_i) begin
            state_q <= COL_WAIT_ACK_LOW;
            pop_q   <= {{(NUM_LANES-1){1'b0}}, 1'b1} << ptr_q;
            ptr_q   <= (ptr_q == PTR_W'(NUM_LANES - 1)) ? '0 : ptr_q + 1'b1;
          end
        end
        COL_WAIT_ACK_LOW: if (!out_ack_i) state_q <= COL_IDLE;
        default: state_q <= COL_IDLE;
      endcase
    end
  end

  // hold the offered result stable for the whole handshake
  always_ff @(posedge clk) begin
    if (offer) res_q <= lane_res_i[ptr_q];
  end

  assign out_req_o  = (state_q == COL_REQ_HIGH);
  assign out_res_o  = res_q;
  assign lane_pop_o = pop_q;

endmodule

//--- design/exu_config.svh
`ifndef EXU_CONFIG_SVH
`define EXU_CONFIG_SVH

// integer register width
`define EXU_XLEN 64

// execute lanes in the cluster, 2 or more
`define EXU_NUM_LANES 4

`endif

//--- design/exu_dispatch.sv
`timescale 1ns/100ps
`include "exu_config.svh"

module exu_dispatch (
  input  logic                      clk,
  input  logic                      rst_n_i,
  input  logic                      in_req_i,
  input  exu_pkg::exu_req_t         in_pkt_i,
  output logic                      in_ack_o,
  input  logic [`EXU_NUM_LANES-1:0] lane_busy_i,
  output logic [`EXU_NUM_LANES-1:0] lane_start_o,
  output exu_pkg::exu_req_t         lane_pkt_o
);

  localparam int NUM_LANES = `EXU_NUM_LANES;
  localparam int PTR_W = $clog2(NUM_LANES);

  typedef enum logic [1:0] {
    DISP_IDLE         = 2'd0,
    DISP_ACK_HIGH     = 2'd1,
    DISP_WAIT_REQ_LOW = 2'd2
  } disp_state_e;

  disp_state_e       state_q;
  disp_state_e       state_d;
  logic [PTR_W-1:0]  ptr_q;
  logic              accept;
  exu_pkg::exu_req_t pkt_q;

  // only the lane under the pointer may take the packet
  assign accept = (state_q == DISP_IDLE) && in_req_i && !lane_busy_i[ptr_q];

  always_comb begin
    state_d = state_q;
    case (state_q)
      DISP_IDLE: if (accept) state_d = DISP_ACK_HIGH;
      // ack_high lasts one cycle, it is the start pulse cycle
      DISP_ACK_HIGH: state_d = in_req_i ? DISP_WAIT_REQ_LOW : DISP_IDLE;
      DISP_WAIT_REQ_LOW: if (!in_req_i) state_d = DISP_IDLE;
      default: state_d = DISP_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      state_q <= DISP_IDLE;
      ptr_q   <= '0;
    end else begin
      state_q <= state_d;
      // advance once the hand-off pulse has gone out
      if (state_q == DISP_ACK_HIGH) begin
        ptr_q <= (ptr_q == PTR_W'(NUM_LANES - 1)) ? '0 : ptr_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) pkt_q <= in_pkt_i;
  end

  assign in_ack_o     = (state_q != DISP_IDLE);
  assign lane_start_o = (state_q == DISP_ACK_HIGH) ?
                        ({{(NUM_LANES-1){1'b0}}, 1'b1} << ptr_q) : '0;
  assign lane_pkt_o   = pkt_q;

endmodule

//--- design/exu_lane.sv
`timescale 1ns/100ps
`include "exu_config.svh"

module exu_lane (
  input  logic              clk,
  input  logic              rst_n_i,
  input  logic              start_i,
  input  exu_pkg::exu_req_t pkt_i,
  input  logic              pop_i,
  output logic              busy_o,
  output logic              valid_o,
  output exu_pkg::exu_res_t res_o
);

  localparam int XLEN = `EXU_XLEN;

  logic              is_alu;
  logic              is_bjp;
  logic              is_jump;
  logic              sub_need;
  logic [XLEN-1:0]   adder_in2;
  logic [XLEN-1:0]   adder_sum;
  logic              adder_cout;
  logic              slt_cmp;
  logic              sltu_cmp;
  logic              eq_cmp;
  logic [5:0]        shamt;
  logic [XLEN-1:0]   sll_res;
  logic [XLEN-1:0]   srl_res;
  logic [XLEN-1:0]   sra_res;
  logic [31:0]       srlw_res;
  logic [31:0]       sraw_res;
  logic [XLEN-1:0]   alu_res;
  logic              branch_taken;
  exu_pkg::exu_res_t res_d;
  exu_pkg::exu_res_t res_q;
  logic              valid_q;

  function automatic logic [XLEN-1:0] sext_w(input logic [31:0] val);
    sext_w = {{(XLEN-32){val[31]}}, val};
  endfunction

  assign is_alu  = (pkt_i.op_class == exu_pkg::EXU_CLASS_ALU);
  assign is_bjp  = (pkt_i.op_class == exu_pkg::EXU_CLASS_BJP);
  assign is_jump = is_bjp && ((pkt_i.bjp_op == exu_pkg::BJP_JAL) ||
                              (pkt_i.bjp_op == exu_pkg::BJP_JALR));

  // compares and conditional branches subtract
  assign sub_need = (is_alu && ((pkt_i.alu_op == exu_pkg::ALU_SUB) ||
                                (pkt_i.alu_op == exu_pkg::ALU_SLT) ||
                                (pkt_i.alu_op == exu_pkg::ALU_SLTU))) ||
                    (is_bjp && !is_jump);

  // one adder for add, sub, compare and link
  assign adder_in2 = sub_need ? ~pkt_i.op2 : pkt_i.op2;
  assign {adder_cout, adder_sum} = {1'b0, pkt_i.op1} + {1'b0, adder_in2} +
                                   {{XLEN{1'b0}}, sub_need};

  // signed lt from operand signs and difference sign
  assign slt_cmp  = (pkt_i.op1[XLEN-1] & ~pkt_i.op2[XLEN-1]) |
                    (~(pkt_i.op1[XLEN-1] ^ pkt_i.op2[XLEN-1]) & adder_sum[XLEN-1]);
  // no carry out means borrow
  assign sltu_cmp = ~adder_cout;
  assign eq_cmp   = ~(|adder_sum);

  assign shamt    = pkt_i.op2[5:0];
  assign sll_res  = pkt_i.op1 << shamt;
  assign srl_res  = pkt_i.op1 >> shamt;
  assign sra_res  = $signed(pkt_i.op1) >>> shamt;
  // word right shifts only see the low half of op1
  assign srlw_res = pkt_i.op1[31:0] >> shamt;
  assign sraw_res = $signed(pkt_i.op1[31:0]) >>> shamt;

  always_comb begin
    case (pkt_i.alu_op)
      exu_pkg::ALU_ADD,
      exu_pkg::ALU_SUB:  alu_res = pkt_i.word_op ? sext_w(adder_sum[31:0]) : adder_sum;
      exu_pkg::ALU_SLL:  alu_res = pkt_i.word_op ? sext_w(sll_res[31:0]) : sll_res;
      exu_pkg::ALU_SLT:  alu_res = {{(XLEN-1){1'b0}}, slt_cmp};
      exu_pkg::ALU_SLTU: alu_res = {{(XLEN-1){1'b0}}, sltu_cmp};
      exu_pkg::ALU_XOR:  alu_res = pkt_i.op1 ^ pkt_i.op2;
      exu_pkg::ALU_SRL:  alu_res = pkt_i.word_op ? sext_w(srlw_res) : srl_res;
      exu_pkg::ALU_SRA:  alu_res = pkt_i.word_op ? sext_w(sraw_res) : sra_res;
      exu_pkg::ALU_OR:   alu_res = pkt_i.op1 | pkt_i.op2;
      exu_pkg::ALU_AND:  alu_res = pkt_i.op1 & pkt_i.op2;
      // upper immediate already placed by the decoder
      exu_pkg::ALU_LUI:  alu_res = pkt_i.op2;
      default:           alu_res = '0;
    endcase
  end

  always_comb begin
    case (pkt_i.bjp_op)
      exu_pkg::BJP_BEQ:  branch_taken = eq_cmp;
      exu_pkg::BJP_BNE:  branch_taken = ~eq_cmp;
      exu_pkg::BJP_BLT:  branch_taken = slt_cmp;
      exu_pkg::BJP_BGE:  branch_taken = ~slt_cmp;
      exu_pkg::BJP_BLTU: branch_taken = sltu_cmp;
      exu_pkg::BJP_BGEU: branch_taken = ~sltu_cmp;
      // jal and jalr
      default:           branch_taken = 1'b1;
    endcase
  end

  always_comb begin
    res_d.rd_wr_en  = pkt_i.rd_wr_en;
    res_d.rd_idx    = pkt_i.rd_idx;
    // link value pc+4 comes out of the adder
    res_d.alu_res   = is_alu ? alu_res : (is_jump ? adder_sum : '0);
    res_d.jump_flag = is_bjp && branch_taken;
    res_d.jump_addr = pkt_i.jp_base + pkt_i.jp_offset;
  end

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      valid_q <= 1'b0;
    end else if (start_i) begin
      valid_q <= 1'b1;
    end else if (pop_i) begin
      valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (start_i) res_q <= res_d;
  end

  // one packet per lane, busy until popped
  assign busy_o  = valid_q;
  assign valid_o = valid_q;
  assign res_o   = res_q;

endmodule

//--- design/exu_pkg.sv
`include "exu_config.svh"

package exu_pkg;

  // operation class from the decoder
  typedef enum logic {
    EXU_CLASS_ALU = 1'b0,
    EXU_CLASS_BJP = 1'b1
  } exu_class_e;

  // integer alu opcodes, word forms use word_op
  typedef enum logic [3:0] {
    ALU_ADD  = 4'd0,
    ALU_SUB  = 4'd1,
    ALU_SLL  = 4'd2,
    ALU_SLT  = 4'd3,
    ALU_SLTU = 4'd4,
    ALU_XOR  = 4'd5,
    ALU_SRL  = 4'd6,
    ALU_SRA  = 4'd7,
    ALU_OR   = 4'd8,
    ALU_AND  = 4'd9,
    ALU_LUI  = 4'd10
  } exu_alu_op_e;

  // branch and jump opcodes
  typedef enum logic [2:0] {
    BJP_JAL  = 3'd0,
    BJP_JALR = 3'd1,
    BJP_BEQ  = 3'd2,
    BJP_BNE  = 3'd3,
    BJP_BLT  = 3'd4,
    BJP_BGE  = 3'd5,
    BJP_BLTU = 3'd6,
    BJP_BGEU = 3'd7
  } exu_bjp_op_e;

  // decoded packet into the stage
  typedef struct packed {
    exu_class_e           op_class;
    exu_alu_op_e          alu_op;
    exu_bjp_op_e          bjp_op;
    logic                 word_op;
    logic                 rd_wr_en;
    logic [4:0]           rd_idx;
    logic [`EXU_XLEN-1:0] op1;
    logic [`EXU_XLEN-1:0] op2;
    logic [`EXU_XLEN-1:0] jp_base;
    logic [`EXU_XLEN-1:0] jp_offset;
  } exu_req_t;

  // write-back and redirect result
  typedef struct packed {
    logic                 rd_wr_en;
    logic [4:0]           rd_idx;
    logic [`EXU_XLEN-1:0] alu_res;
    logic                 jump_flag;
    logic [`EXU_XLEN-1:0] jump_addr;
  } exu_res_t;

endpackage

//--- design/exu_top.sv
`timescale 1ns/100ps
`include "exu_config.svh"

module exu_top (
  input  logic              clk,
  input  logic              rst_n_i,
  input  logic              in_req_i,
  input  exu_pkg::exu_req_t in_pkt_i,
  output logic              in_ack_o,
  output logic              out_req_o,
  output exu_pkg::exu_res_t out_res_o,
  input  logic              out_ack_i
);

  logic [`EXU_NUM_LANES-1:0] lane_busy;
  logic [`EXU_NUM_LANES-1:0] lane_start;
  logic [`EXU_NUM_LANES-1:0] lane_valid;
  logic [`EXU_NUM_LANES-1:0] lane_pop;
  exu_pkg::exu_req_t         lane_pkt;
  exu_pkg::exu_res_t         lane_res [`EXU_NUM_LANES];

  exu_dispatch i_dispatch (
    .clk          (clk),
    .rst_n_i      (rst_n_i),
    .in_req_i     (in_req_i),
    .in_pkt_i     (in_pkt_i),
    .in_ack_o     (in_ack_o),
    .lane_busy_i  (lane_busy),
    .lane_start_o (lane_start),
    .lane_pkt_o   (lane_pkt)
  );

  // all lanes share the dispatched packet bus
  for (genvar i = 0; i < `EXU_NUM_LANES; i++) begin : g_lane
    exu_lane i_lane (
      .clk     (clk),
      .rst_n_i (rst_n_i),
      .start_i (lane_start[i]),
      .pkt_i   (lane_pkt),
      .pop_i   (lane_pop[i]),
      .busy_o  (lane_busy[i]),
      .valid_o (lane_valid[i]),
      .res_o   (lane_res[i])
    );
  end

  exu_collect i_collect (
    .clk          (clk),
    .rst_n_i      (rst_n_i),
    .lane_valid_i (lane_valid),
    .lane_res_i   (lane_res),
    .lane_pop_o   (lane_pop),
    .out_req_o    (out_req_o),
    .out_res_o    (out_res_o),
    .out_ack_i    (out_ack_i)
  );

endmodule

//--- sim.f
+incdir+design
design/exu_pkg.sv
design/exu_dispatch.sv
design/exu_lane.sv
design/exu_collect.sv
design/exu_top.sv
verif/exu_checker.sv
verif/exu_tb.sv

//--- verif/exu_checker.sv
`timescale 1ns/100ps
`include "exu_config.svh"

module exu_checker (
  input  logic              clk,
  input  logic              rst_n_i,
  input  logic              in_req_i,
  input  exu_pkg::exu_req_t in_pkt_i,
  input  logic              in_ack_i,
  input  logic              out_req_i,
  input  exu_pkg::exu_res_t out_res_i,
  input  logic              done_i,
  output int                err_cnt_o,
  output int                res_cnt_o
);

  localparam int NUM_LANES = `EXU_NUM_LANES;

  exu_pkg::exu_req_t pend_q[$];
  exu_pkg::exu_res_t exp_res;
  logic              in_ack_prev;
  logic              out_req_prev;
  logic              seen_req = 1'b0;
  logic              lanes_filled = 1'b0;
  logic              done_seen = 1'b0;
  int                accepted = 0;
  int                completed = 0;

  // reference result straight from the RV64I rules
  function automatic exu_pkg::exu_res_t ref_result(input exu_pkg::exu_req_t p);
    exu_pkg::exu_res_t   r;
    logic [`EXU_XLEN-1:0] a;
    logic [`EXU_XLEN-1:0] b;
    logic [31:0]          w;
    logic                 word_sel;
    a = p.op1;
    b = p.op2;
    r.rd_wr_en  = p.rd_wr_en;
    r.rd_idx    = p.rd_idx;
    r.jump_addr = p.jp_base + p.jp_offset;
    r.jump_flag = 1'b0;
    r.alu_res   = '0;
    if (p.op_class == exu_pkg::EXU_CLASS_ALU) begin
      case (p.alu_op)
        exu_pkg::ALU_ADD:  r.alu_res = a + b;
        exu_pkg::ALU_SUB:  r.alu_res = a - b;
        exu_pkg::ALU_SLL:  r.alu_res = a << b[5:0];
        exu_pkg::ALU_SLT:  r.alu_res = ($signed(a) < $signed(b)) ? 1 : 0;
        exu_pkg::ALU_SLTU: r.alu_res = (a < b) ? 1 : 0;
        exu_pkg::ALU_XOR:  r.alu_res = a ^ b;
        exu_pkg::ALU_SRL:  r.alu_res = a >> b[5:0];
        exu_pkg::ALU_SRA:  r.alu_res = $signed(a) >>> b[5:0];
        exu_pkg::ALU_OR:   r.alu_res = a | b;
        exu_pkg::ALU_AND:  r.alu_res = a & b;
        exu_pkg::ALU_LUI:  r.alu_res = b;
        default:           r.alu_res = '0;
      endcase
      // word forms work on the low half and sign-extend
      if (p.word_op) begin
        word_sel = 1'b1;
        case (p.alu_op)
          exu_pkg::ALU_ADD: w = a[31:0] + b[31:0];
          exu_pkg::ALU_SUB: w = a[31:0] - b[31:0];
          exu_pkg::ALU_SLL: w = a[31:0] << b[5:0];
          exu_pkg::ALU_SRL: w = a[31:0] >> b[5:0];
          exu_pkg::ALU_SRA: w = $signed(a[31:0]) >>> b[5:0];
          default:          word_sel = 1'b0;
        endcase
        if (word_sel) begin
          r.alu_res = {{(`EXU_XLEN-32){w[31]}}, w};
        end
      end
    end else begin
      case (p.bjp_op)
        exu_pkg::BJP_BEQ:  r.jump_flag = (a == b);
        exu_pkg::BJP_BNE:  r.jump_flag = (a != b);
        exu_pkg::BJP_BLT:  r.jump_flag = ($signed(a) < $signed(b));
        exu_pkg::BJP_BGE:  r.jump_flag = ($signed(a) >= $signed(b));
        exu_pkg::BJP_BLTU: r.jump_flag = (a < b);
        exu_pkg::BJP_BGEU: r.jump_flag = (a >= b);
        default: begin
          r.jump_flag = 1'b1;
          r.alu_res   = a + b;
        end
      endcase
    end
    return r;
  endfunction

  function automatic string diff_fields(input exu_pkg::exu_res_t got,
                                        input exu_pkg::exu_res_t exp);
    string s;
    s = "";
    if (got.rd_wr_en !== exp.rd_wr_en) s = {s, " rd_wr_en"};
    if (got.rd_idx !== exp.rd_idx) s = {s, " rd_idx"};
    if (got.alu_res !== exp.alu_res) s = {s, " alu_res"};
    if (got.jump_flag !== exp.jump_flag) s = {s, " jump_flag"};
    if (got.jump_addr !== exp.jump_addr) s = {s, " jump_addr"};
    return s;
  endfunction

  // sampled on the rising edge, before the DUT registers update
  always @(posedge clk) begin
    if (!rst_n_i) begin
      in_ack_prev  = 1'b0;
      out_req_prev = 1'b0;
      err_cnt_o    = 0;
      res_cnt_o    = 0;
    end else begin
      if (!seen_req && (in_ack_i || out_req_i)) begin
        err_cnt_o++;
        $display("ack or result request went high at %0t before any request", $time);
      end
      if (in_req_i) seen_req = 1'b1;
      if (in_ack_i && !in_ack_prev) begin
        pend_q.push_back(in_pkt_i);
        accepted++;
      end
      if (out_req_i && !out_req_prev) begin
        if (pend_q.size() == 0) begin
          err_cnt_o++;
          $display("result offered at %0t with no packet outstanding", $time);
        end else begin
          exp_res = ref_result(pend_q.pop_front());
          if (out_res_i !== exp_res) begin
            err_cnt_o++;
            $display("CHECK FAILED at %0t: result %0d wrong in%s", $time, res_cnt_o,
                     diff_fields(out_res_i, exp_res));
            $display("  alu_res %h exp %h, jump_addr %h exp %h", out_res_i.alu_res,
                     exp_res.alu_res, out_res_i.jump_addr, exp_res.jump_addr);
          end
        end
        res_cnt_o++;
      end
      if (!out_req_i && out_req_prev) completed++;
      // one packet per lane at most
      if (accepted - completed > NUM_LANES) begin
        err_cnt_o++;
        $display("more packets accepted than lanes can hold at %0t", $time);
      end
      if (accepted - completed == NUM_LANES) lanes_filled = 1'b1;
      if (done_i && !done_seen) begin
        done_seen = 1'b1;
        if (pend_q.size() != 0) begin
          err_cnt_o++;
          $display("%0d accepted packets never produced a result", pend_q.size());
        end
        if (!lanes_filled) begin
          err_cnt_o++;
          $display("lanes never all filled during the output stall");
        end
      end
      in_ack_prev  = in_ack_i;
      out_req_prev = out_req_i;
    end
  end

endmodule

//--- verif/exu_tb.sv
`timescale 1ns/100ps
`include "exu_config.svh"

module exu_tb;

  localparam int STALL_CYCLES = (`EXU_NUM_LANES * 3 > 12) ? `EXU_NUM_LANES * 3 : 12;

  logic              clk;
  logic              rst_n;
  logic              in_req;
  exu_pkg::exu_req_t in_pkt;
  logic              in_ack;
  logic              out_req;
  exu_pkg::exu_res_t out_res;
  logic              out_ack;
  logic              done;
  int                err_cnt;
  int                res_cnt;
  int                seed = 32'h952b_4f29;
  int                stall_idx = -1;
  int                sink_cnt = 0;
  logic              table_ready = 1'b0;
  exu_pkg::exu_req_t vec_q[$];

  exu_top i_dut (
    .clk       (clk),
    .rst_n_i   (rst_n),
    .in_req_i  (in_req),
    .in_pkt_i  (in_pkt),
    .in_ack_o  (in_ack),
    .out_req_o (out_req),
    .out_res_o (out_res),
    .out_ack_i (out_ack)
  );

  exu_checker i_checker (
    .clk       (clk),
    .rst_n_i   (rst_n),
    .in_req_i  (in_req),
    .in_pkt_i  (in_pkt),
    .in_ack_i  (in_ack),
    .out_req_i (out_req),
    .out_res_i (out_res),
    .done_i    (done),
    .err_cnt_o (err_cnt),
    .res_cnt_o (res_cnt)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  function automatic logic [`EXU_XLEN-1:0] rnd64();
    return {$random(seed), $random(seed)};
  endfunction

  function automatic exu_pkg::exu_req_t alu_packet(input exu_pkg::exu_alu_op_e op,
                                                  input logic word,
                                                  input logic [`EXU_XLEN-1:0] a,
                                                  input logic [`EXU_XLEN-1:0] b);
    exu_pkg::exu_req_t p;
    p = '0;
    p.op_class = exu_pkg::EXU_CLASS_ALU;
    p.alu_op   = op;
    p.word_op  = word;
    p.op1      = a;
    p.op2      = b;
    return p;
  endfunction

  function automatic exu_pkg::exu_req_t branch_packet(input exu_pkg::exu_bjp_op_e op,
                                                     input logic [`EXU_XLEN-1:0] a,
                                                     input logic [`EXU_XLEN-1:0] b);
    exu_pkg::exu_req_t p;
    p = '0;
    p.op_class  = exu_pkg::EXU_CLASS_BJP;
    p.bjp_op    = op;
    p.op1       = a;
    p.op2       = b;
    p.jp_base   = rnd64();
    p.jp_offset = rnd64();
    return p;
  endfunction

  task automatic build_table();
    logic [`EXU_XLEN-1:0] m1;
    logic [`EXU_XLEN-1:0] min;
    logic [`EXU_XLEN-1:0] pa [3];
    logic [`EXU_XLEN-1:0] pb [3];
    m1  = '1;
    min = {1'b1, {(`EXU_XLEN-1){1'b0}}};
    // 64-bit alu forms
    vec_q.push_back(alu_packet(exu_pkg::ALU_ADD, 1'b0, 64'd5, 64'd7));
    vec_q.push_back(alu_packet(exu_pkg::ALU_ADD, 1'b0, m1, 64'd1));
    vec_q.push_back(alu_packet(exu_pkg::ALU_SUB, 1'b0, 64'd3, 64'd5));
    vec_q.push_back(alu_packet(exu_pkg::ALU_SUB, 1'b0, min, 64'd1));
    vec_q.push_back(alu_packet(exu_pkg::ALU_SLT, 1'b0, m1, 64'd1));
    vec_q.push_back(alu_packet(exu_pkg::ALU_SLT, 1'b0, 64'd1, m1));
    vec_q.push_back(alu_packet(exu_pkg::ALU_SLT, 1'b0, 64'd9, 64'd9));
    vec_q.push_back(alu_packet(exu_pkg::ALU_SLTU, 1'b0, m1, 64'd1));
    vec_q.push_back(alu_packet(exu_pkg::ALU_SLTU, 1'b0, 64'd1, m1));
    vec_q.push_back(alu_packet(exu_pkg::ALU_SLL, 1'b0, 64'h0123_4567_89ab_cdef, 64'd0));
    vec_q.push_back(alu_packet(exu_pkg::ALU_SLL, 1'b0, 64'd1, 64'd63));
    vec_q.push_back(alu_packet(exu_pkg::ALU_SRL, 1'b0, min, 64'd63));
    vec_q.push_back(alu_packet(exu_pkg::ALU_SRA, 1'b0, min, 64'd63));
    vec_q.push_back(alu_packet(exu_pkg::ALU_SRA, 1'b0, min, 64'd0));
    vec_q.push_back(alu_packet(exu_pkg::ALU_XOR, 1'b0, rnd64(), rnd64()));
    vec_q.push_back(alu_packet(exu_pkg::ALU_OR, 1'b0, rnd64(), rnd64()));
    vec_q.push_back(alu_packet(exu_pkg::ALU_AND, 1'b0, rnd64(), rnd64()));
    vec_q.push_back(alu_packet(exu_pkg::ALU_LUI, 1'b0, rnd64(), 64'hffff_ffff_8000_0000));
    // word forms with bit 31 set in several results
    vec_q.push_back(alu_packet(exu_pkg::ALU_ADD, 1'b1, 64'h0000_0000_7fff_ffff, 64'd1));
    vec_q.push_back(alu_packet(exu_pkg::ALU_SUB, 1'b1, 64'h1234_0000_0000_0000, 64'd1));
    vec_q.push_back(alu_packet(exu_pkg::ALU_SLL, 1'b1, 64'd1, 64'd31));
    vec_q.push_back(alu_packet(exu_pkg::ALU_SLL, 1'b1, 64'hdead_beef_0f0f_0f0f, 64'd4));
    vec_q.push_back(alu_packet(exu_pkg::ALU_SRL, 1'b1, 64'hffff_ffff_8000_0000, 64'd4));
    vec_q.push_back(alu_packet(exu_pkg::ALU_SRL, 1'b1, 64'h0000_0001_8000_0000, 64'd0));
    vec_q.push_back(alu_packet(exu_pkg::ALU_SRA, 1'b1, 64'h0000_0000_8000_0000, 64'd4));
    // equal, signed less and signed greater pairs for every branch
    pa = '{64'd5, m1, 64'd1};
    pb = '{64'd5, 64'd1, m1};
    for (int k = 2; k < 8; k++) begin
      for (int j = 0; j < 3; j++) begin
        vec_q.push_back(branch_packet(exu_pkg::exu_bjp_op_e'(k), pa[j], pb[j]));
      end
    end
    vec_q.push_back(branch_packet(exu_pkg::BJP_JAL, 64'h0000_0000_8000_1000, 64'd4));
    vec_q.push_back(branch_packet(exu_pkg::BJP_JALR, 64'hffff_ffff_ffff_fffc, 64'd4));
    // back-pressure run with more packets than lanes
    stall_idx = vec_q.size();
    for (int k = 0; k < 2 * `EXU_NUM_LANES; k++) begin
      vec_q.push_back(alu_packet((k % 2) ? exu_pkg::ALU_XOR : exu_pkg::ALU_SUB, 1'b0,
                                 rnd64(), rnd64()));
    end
    foreach (vec_q[i]) begin
      vec_q[i].rd_wr_en = $random(seed);
      vec_q[i].rd_idx   = $random(seed);
    end
  endtask

  // called on a falling edge with ack low
  task automatic send_pkt(input exu_pkg::exu_req_t pkt);
    in_pkt = pkt;
    in_req = 1'b1;
    do @(negedge clk); while (!in_ack);
    in_req = 1'b0;
    do @(negedge clk); while (in_ack);
  endtask

  // result sink with random ack delay
  initial begin : sink
    int delay;
    out_ack = 1'b0;
    forever begin
      @(negedge clk);
      if (out_req === 1'b1) begin
        delay = (sink_cnt == stall_idx) ? STALL_CYCLES : $unsigned($random(seed)) % 6;
        repeat (delay) @(negedge clk);
        out_ack = 1'b1;
        sink_cnt++;
        do @(negedge clk); while (out_req);
        out_ack = 1'b0;
      end
    end
  end

  initial begin : watchdog
    int limit;
    wait (table_ready);
    limit = vec_q.size() * 20 + 200;
    repeat (limit) @(posedge clk);
    $display("timeout after %0d cycles with %0d results received", limit, res_cnt);
    $display("errors: %0d", err_cnt + 1);
    $display("Test failed");
    $finish;
  end

  initial begin
    rst_n  = 1'b0;
    in_req = 1'b0;
    in_pkt = '0;
    done   = 1'b0;
    build_table();
    table_ready = 1'b1;
    repeat (3) @(negedge clk);
    rst_n = 1'b1;
    // idle gap so the post-reset outputs can be watched
    repeat (4) @(negedge clk);
    foreach (vec_q[i]) send_pkt(vec_q[i]);
    while (res_cnt < vec_q.size()) @(negedge clk);
    done = 1'b1;
    repeat (2) @(negedge clk);
    $display("errors: %0d", err_cnt);
    if (err_cnt == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule
